/* files.f */
bitmap_pkg.sv
cmd_decoder.sv
ack_window.sv
hole_finder.sv
bitmap_ctrl.sv
bitmap_ctrl_asserts.sv
tb_clock.sv
tb_bitmap_ctrl.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the bitmap controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_bitmap_ctrl -f files.f --Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_bitmap_ctrl +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "tests failed" sim.log; then
  exit 1
fi
if ! grep -q "all tests passed" sim.log; then
  echo "simulation log holds no result line"
  exit 1
fi
exit 0

/* tb_bitmap_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_bitmap_ctrl;

  localparam int RESET_CYCLES = 2;
  localparam int IDLE_CYCLES  = 6;
  localparam int RAND_CMDS    = 200;

  wire                   clk;
  wire                   rst_n;
  bitmap_pkg::cmd_word_t cmd_data;
  logic                  cmd_empty;
  wire                   cmd_rd_en;
  bitmap_pkg::report_t   report_data;
  wire                   report_wr_en;
  logic                  report_full;

  bitmap_pkg::cmd_word_t cmd_q[$];
  bitmap_pkg::shift_t    exp_q[$];
  bitmap_pkg::window_t   model_win;
  bitmap_pkg::shift_t    exp_pos;
  logic [31:0]           lfsr;
  logic                  feed_en;
  logic                  rd_pending;
  logic                  rd_prev;
  logic                  gap;
  int                    err_cnt;
  int                    rep_cnt;
  int                    cycle_cnt;
  int                    cycle_limit;

  tb_clock i_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  bitmap_ctrl i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_data     (cmd_data),
    .cmd_empty    (cmd_empty),
    .cmd_rd_en    (cmd_rd_en),
    .report_data  (report_data),
    .report_wr_en (report_wr_en),
    .report_full  (report_full)
  );

  bind bitmap_ctrl bitmap_ctrl_asserts i_asserts (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_rd_en    (cmd_rd_en),
    .cmd_empty    (cmd_empty),
    .report_wr_en (report_wr_en),
    .report_full  (report_full)
  );

  //////////////////////////////
  // random source
  //////////////////////////////
  function automatic logic lfsr_bit();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) begin
      lfsr = lfsr ^ 32'hA300_0000;
    end
    return out;
  endfunction

  function automatic int rand_bits(int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr_bit());
    end
    return v;
  endfunction

  //////////////////////////////
  // reference model
  //////////////////////////////
  function automatic bitmap_pkg::window_t mark_ref(bitmap_pkg::window_t w, logic sv, int ss,
                                                   logic av, int as_cnt);
    bitmap_pkg::window_t r;
    r = w;
    if (sv && ss < bitmap_pkg::WINDOW_BITS) begin
      r[ss] = 1'b1;
    end
    if (av) begin
      if (as_cnt >= bitmap_pkg::WINDOW_BITS) begin
        r = '0;
      end else begin
        r = r >> as_cnt;
      end
    end
    // base moves onto the first missing packet
    while (r[0]) begin
      r = r >> 1;
    end
    return r;
  endfunction

  // first zero above the offset where bits past the window count as missing
  function automatic int hole_ref(bitmap_pkg::window_t w, int offset);
    int j;
    j = offset + 1;
    while (j < bitmap_pkg::WINDOW_BITS && w[j]) begin
      j++;
    end
    return j;
  endfunction

  //////////////////////////////
  // command builders
  //////////////////////////////
  task automatic push_mark(logic sv, int ss, logic av, int as_cnt);
    bitmap_pkg::cmd_word_t w;
    w = '0;
    w[31:30] = bitmap_pkg::op_mark;
    w[bitmap_pkg::MARK_SACK_VALID_BIT] = sv;
    w[bitmap_pkg::MARK_AACK_VALID_BIT] = av;
    w[bitmap_pkg::AACK_SHIFT_LSB +: bitmap_pkg::SHIFT_BITS] = bitmap_pkg::shift_t'(as_cnt);
    w[bitmap_pkg::SHIFT_BITS-1:0] = bitmap_pkg::shift_t'(ss);
    cmd_q.push_back(w);
    model_win = mark_ref(model_win, sv, ss, av, as_cnt);
  endtask

  task automatic push_find(int offset);
    bitmap_pkg::cmd_word_t w;
    w = '0;
    w[31:30] = bitmap_pkg::op_find;
    w[bitmap_pkg::SHIFT_BITS-1:0] = bitmap_pkg::shift_t'(offset);
    cmd_q.push_back(w);
    exp_q.push_back(bitmap_pkg::shift_t'(hole_ref(model_win, offset)));
  endtask

  task automatic push_other(bitmap_pkg::opcode_t op, int payload);
    bitmap_pkg::cmd_word_t w;
    w = bitmap_pkg::cmd_word_t'(payload);
    w[31:30] = op;
    cmd_q.push_back(w);
  endtask

  task automatic build_cmds();
    int   sel;
    logic sv;
    logic av;
    int   ss;
    int   as_cnt;
    push_find(0);
    // sparse sacks and then the drain from bit 0
    push_mark(1'b1, 3, 1'b0, 0);
    push_mark(1'b1, 5, 1'b0, 0);
    push_mark(1'b1, 6, 1'b0, 0);
    push_find(0);
    push_find(2);
    push_mark(1'b1, 1, 1'b0, 0);
    push_mark(1'b1, 2, 1'b0, 0);
    push_mark(1'b1, 0, 1'b0, 0);
    push_find(0);
    push_find(1);
    // sack and cumulative ack in one word
    push_mark(1'b1, 4, 1'b1, 2);
    push_mark(1'b1, 9, 1'b1, 3);
    push_find(0);
    push_find(4);
    push_mark(1'b1, 1, 1'b1, 1);
    push_find(0);
    push_mark(1'b0, 0, 1'b1, 200);
    push_find(0);
    // fill 1..100 so holes land in the upper banks
    for (int i = 1; i <= 100; i++) begin
      push_mark(1'b1, i, 1'b0, 0);
    end
    push_find(0);
    push_find(10);
    push_find(40);
    push_find(70);
    push_find(100);
    push_find(127);
    push_find(150);
    push_find(199);
    push_other(bitmap_pkg::op_cut, 32'h0000_0005);
    push_other(bitmap_pkg::op_preread, 32'h3fff_ffff);
    push_find(0);
    push_find(40);
    for (int n = 0; n < RAND_CMDS; n++) begin
      sel = rand_bits(3);
      if (sel == 0) begin
        push_other(bitmap_pkg::op_cut, rand_bits(30));
      end else if (sel == 7) begin
        push_other(bitmap_pkg::op_preread, rand_bits(30));
      end else if (sel <= 4) begin
        sv = lfsr_bit();
        ss = rand_bits(8);
        av = (rand_bits(2) == 0);
        as_cnt = (rand_bits(3) == 0) ? rand_bits(14) : rand_bits(5);
        push_mark(sv, ss, av, as_cnt);
      end else begin
        push_find(rand_bits(8) % 200);
      end
    end
    // the last report marks the end of the run
    push_find(rand_bits(8) % 200);
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial begin
    cmd_data    = '0;
    cmd_empty   = 1'b1;
    report_full = 1'b0;
    lfsr        = 32'h3517_5b5d;
    model_win   = '0;
    feed_en     = 1'b0;
    rd_pending  = 1'b0;
    rd_prev     = 1'b0;
    gap         = 1'b0;
    err_cnt     = 0;
    rep_cnt     = 0;
    cycle_cnt   = 0;
    build_cmds();
    cycle_limit = 40 * cmd_q.size() + RESET_CYCLES + IDLE_CYCLES;
    wait (rst_n === 1'b1);
    // empty fifo keeps both strobes low
    repeat (IDLE_CYCLES) begin
      @(negedge clk);
      #1;
      if (cmd_rd_en !== 1'b0) begin
        err_cnt++;
        $display("FAILED at %0t: cmd_rd_en expected 0, actual %b", $time, cmd_rd_en);
      end
      if (report_wr_en !== 1'b0) begin
        err_cnt++;
        $display("FAILED at %0t: report_wr_en expected 0, actual %b", $time, report_wr_en);
      end
    end
    feed_en = 1'b1;
    while (cmd_q.size() != 0 || exp_q.size() != 0) begin
      @(negedge clk);
    end
    // catch any stray report after the last one
    repeat (8) @(negedge clk);
    $display("errors: %0d, reports: %0d", err_cnt, rep_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  //////////////////////////////
  // command fifo model
  //////////////////////////////
  always @(negedge clk) begin
    if (feed_en) begin
      if (rd_pending) begin
        if (cmd_q.size() == 0) begin
          err_cnt++;
          $display("command FIFO read at %0t while no command was left", $time);
        end else begin
          cmd_data = cmd_q.pop_front();
        end
      end
      gap         = (rand_bits(2) == 0);
      cmd_empty   = (cmd_q.size() == 0) || gap;
      report_full = (rand_bits(2) == 0);
      #1;
      rd_pending = cmd_rd_en;
      if (cmd_rd_en && cmd_empty) begin
        err_cnt++;
        $display("command read at %0t while the command FIFO was empty", $time);
      end
      if (cmd_rd_en && rd_prev) begin
        err_cnt++;
        $display("command read strobe high two cycles in a row at %0t", $time);
      end
      rd_prev = cmd_rd_en;
    end
  end

  //////////////////////////////
  // report compare
  //////////////////////////////
  always @(negedge clk) begin
    #1;
    if (rst_n && report_wr_en) begin
      rep_cnt++;
      if (report_full) begin
        err_cnt++;
        $display("report written at %0t while the report FIFO was full", $time);
      end
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("unexpected report %h at %0t with no find pending", report_data, $time);
      end else begin
        exp_pos = exp_q.pop_front();
        if (report_data[15:14] !== bitmap_pkg::REPORT_TAG_HOLE) begin
          err_cnt++;
          $display("FAILED at %0t: report_data[15:14] expected %b, actual %b",
                   $time, bitmap_pkg::REPORT_TAG_HOLE, report_data[15:14]);
        end
        if (report_data[13:0] !== exp_pos) begin
          err_cnt++;
          $display("FAILED at %0t: report_data[13:0] expected %0d, actual %0d",
                   $time, exp_pos, report_data[13:0]);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("run timed out after %0d cycles", cycle_cnt);
      $display("errors: %0d, reports: %0d", err_cnt, rep_cnt);
      $display("tests failed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD  = 20;
  localparam int RESET_CYCLES = 2;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // release away from the rising edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* bitmap_ctrl_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module bitmap_ctrl_asserts (
  input wire clk,
  input wire rst_n,
  input wire cmd_rd_en,
  input wire cmd_empty,
  input wire report_wr_en,
  input wire report_full
);

  //////////////////////////////
  // fifo strobes
  //////////////////////////////
  a_no_read_when_empty: assert property (
    @(posedge clk) disable iff (!rst_n) !(cmd_rd_en && cmd_empty)
  ) else $error("command read issued while the command FIFO is empty");

  a_no_write_when_full: assert property (
    @(posedge clk) disable iff (!rst_n) !(report_wr_en && report_full)
  ) else $error("report write issued while the report FIFO is full");

  // one read, then at least one cycle of decode
  a_single_cycle_read: assert property (
    @(posedge clk) disable iff (!rst_n) cmd_rd_en |=> !cmd_rd_en
  ) else $error("command read strobe high for two cycles in a row");

endmodule

`default_nettype wire

/* bitmap_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module bitmap_ctrl (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire bitmap_pkg::cmd_word_t cmd_data,
  input  wire                        cmd_empty,
  output logic                       cmd_rd_en,
  output bitmap_pkg::report_t        report_data,
  output logic                       report_wr_en,
  input  wire                        report_full
);

  // decoder to window
  logic                mark_strobe;
  logic                sack_valid;
  logic                aack_valid;
  bitmap_pkg::shift_t  sack_shift;
  bitmap_pkg::shift_t  aack_shift;

  // decoder to finder
  logic                find_strobe;
  bitmap_pkg::shift_t  find_offset;
  logic                find_done;

  bitmap_pkg::window_t window;

  //////////////////////////////
  // command side
  //////////////////////////////
  cmd_decoder i_cmd_decoder (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_data    (cmd_data),
    .cmd_empty   (cmd_empty),
    .cmd_rd_en   (cmd_rd_en),
    .mark_strobe (mark_strobe),
    .sack_valid  (sack_valid),
    .aack_valid  (aack_valid),
    .sack_shift  (sack_shift),
    .aack_shift  (aack_shift),
    .find_strobe (find_strobe),
    .find_offset (find_offset),
    .find_done   (find_done)
  );

  ack_window i_ack_window (
    .clk         (clk),
    .rst_n       (rst_n),
    .mark_strobe (mark_strobe),
    .sack_valid  (sack_valid),
    .aack_valid  (aack_valid),
    .sack_shift  (sack_shift),
    .aack_shift  (aack_shift),
    .window      (window)
  );

  //////////////////////////////
  // report side
  //////////////////////////////
  hole_finder i_hole_finder (
    .clk          (clk),
    .rst_n        (rst_n),
    .find_strobe  (find_strobe),
    .find_offset  (find_offset),
    .window       (window),
    .find_done    (find_done),
    .report_data  (report_data),
    .report_wr_en (report_wr_en),
    .report_full  (report_full)
  );

endmodule

`default_nettype wire

/* hole_finder.sv */
`timescale 1ns/10ps
`default_nettype none

module hole_finder (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      find_strobe,
  input  wire bitmap_pkg::shift_t  find_offset,
  input  wire bitmap_pkg::window_t window,
  output logic                     find_done,
  output bitmap_pkg::report_t      report_data,
  output logic                     report_wr_en,
  input  wire                      report_full
);

  typedef enum logic [1:0] {
    fs_idle,
    fs_select,
    fs_encode,
    fs_report
  } find_state_t;

  find_state_t                          state;
  logic [bitmap_pkg::SHIFT_BITS:0]      first_bit;
  bitmap_pkg::window_t                  shifted_q;
  bitmap_pkg::shift_t                   offset_q;
  logic [bitmap_pkg::BANK_BITS-1:0]     bank_sel;
  bitmap_pkg::bank_idx_t                bank_sel_idx;
  logic [bitmap_pkg::BANK_BITS-1:0]     bank_q;
  bitmap_pkg::bank_idx_t                bank_idx_q;
  bitmap_pkg::bank_pos_t                zero_pos;
  bitmap_pkg::shift_t                   hole_pos;

  // search starts one above the offset
  assign first_bit = {1'b0, find_offset} + {{bitmap_pkg::SHIFT_BITS{1'b0}}, 1'b1};

  //////////////////////////////
  // control
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= fs_idle;
    end else begin
      case (state)
        fs_idle:   if (find_strobe) state <= fs_select;
        fs_select: state <= fs_encode;
        fs_encode: state <= fs_report;
        // hold the report while the fifo is full
        fs_report: if (!report_full) state <= fs_idle;
        default:   state <= fs_idle;
      endcase
    end
  end

  assign report_wr_en = (state == fs_report) && !report_full;
  assign find_done    = report_wr_en;

  //////////////////////////////
  // stage 1 aligns the window
  //////////////////////////////
  // bits shifted in from above 127 read as zero
  always_ff @(posedge clk) begin
    if (state == fs_idle && find_strobe) begin
      shifted_q <= window >> first_bit;
      offset_q  <= find_offset;
    end
  end

  //////////////////////////////
  // stage 2 selects the bank
  //////////////////////////////
  // top bank always holds a zero after the shift
  always_comb begin
    bank_sel_idx = bitmap_pkg::bank_idx_t'(bitmap_pkg::N_BANKS - 1);
    for (int b = bitmap_pkg::N_BANKS - 1; b >= 0; b--) begin
      if (shifted_q[b*bitmap_pkg::BANK_BITS +: bitmap_pkg::BANK_BITS] != '1) begin
        bank_sel_idx = bitmap_pkg::bank_idx_t'(b);
      end
    end
    bank_sel = shifted_q[bank_sel_idx*bitmap_pkg::BANK_BITS +: bitmap_pkg::BANK_BITS];
  end

  always_ff @(posedge clk) begin
    if (state == fs_select) begin
      bank_q     <= bank_sel;
      bank_idx_q <= bank_sel_idx;
    end
  end

  //////////////////////////////
  // stage 3 encodes and reports
  //////////////////////////////
  always_comb begin
    zero_pos = '1;
    for (int i = bitmap_pkg::BANK_BITS - 1; i >= 0; i--) begin
      if (!bank_q[i]) begin
        zero_pos = bitmap_pkg::bank_pos_t'(i);
      end
    end
  end

  // offset + 1 + 32 * bank + bit
  assign hole_pos = offset_q + bitmap_pkg::shift_t'(1)
                  + bitmap_pkg::shift_t'(bank_idx_q)
                    * bitmap_pkg::shift_t'(bitmap_pkg::BANK_BITS)
                  + bitmap_pkg::shift_t'(zero_pos);

  always_ff @(posedge clk) begin
    if (state == fs_encode) begin
      report_data <= {bitmap_pkg::REPORT_TAG_HOLE, hole_pos};
    end
  end

endmodule

`default_nettype wire

/* ack_window.sv */
`timescale 1ns/10ps
`default_nettype none

module ack_window (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     mark_strobe,
  input  wire                     sack_valid,
  input  wire                     aack_valid,
  input  wire bitmap_pkg::shift_t sack_shift,
  input  wire bitmap_pkg::shift_t aack_shift,
  output bitmap_pkg::window_t     window
);

  bitmap_pkg::window_t  win_sack;
  bitmap_pkg::window_t  win_aack;
  bitmap_pkg::window_t  win_next;
  bitmap_pkg::win_cnt_t ones_cnt;

  //////////////////////////////
  // mark update
  //////////////////////////////
  // step 1 sets the selectively acked bit
  always_comb begin
    win_sack = window;
    if (sack_valid && sack_shift < bitmap_pkg::WINDOW_BITS) begin
      win_sack = win_sack | (bitmap_pkg::window_t'(1) << sack_shift);
    end
  end

  // step 2 lets the cumulative ack move the base
  always_comb begin
    win_aack = win_sack;
    if (aack_valid) begin
      win_aack = win_sack >> aack_shift;
    end
  end

  // step 3 counts trailing ones where the lowest zero wins
  always_comb begin
    ones_cnt = bitmap_pkg::win_cnt_t'(bitmap_pkg::WINDOW_BITS);
    for (int i = bitmap_pkg::WINDOW_BITS - 1; i >= 0; i--) begin
      if (!win_aack[i]) begin
        ones_cnt = bitmap_pkg::win_cnt_t'(i);
      end
    end
  end

  // base lands on the first missing packet
  assign win_next = win_aack >> ones_cnt;

  //////////////////////////////
  // window register
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      window <= '0;
    end else if (mark_strobe) begin
      window <= win_next;
    end
  end

endmodule

`default_nettype wire

/* cmd_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module cmd_decoder (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire bitmap_pkg::cmd_word_t cmd_data,
  input  wire                        cmd_empty,
  output logic                       cmd_rd_en,
  output logic                       mark_strobe,
  output logic                       sack_valid,
  output logic                       aack_valid,
  output bitmap_pkg::shift_t         sack_shift,
  output bitmap_pkg::shift_t         aack_shift,
  output logic                       find_strobe,
  output bitmap_pkg::shift_t         find_offset,
  input  wire                        find_done
);

  typedef enum logic [1:0] {
    st_idle,
    st_decode,
    st_busy_find
  } dec_state_t;

  dec_state_t          state;
  dec_state_t          state_next;
  bitmap_pkg::opcode_t opcode;

  // fifo word is valid in decode one cycle after the read
  assign opcode    = bitmap_pkg::opcode_t'(cmd_data[31:30]);
  assign cmd_rd_en = (state == st_idle) && !cmd_empty;

  //////////////////////////////
  // state machine
  //////////////////////////////
  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (cmd_rd_en) begin
          state_next = st_decode;
        end
      end
      st_decode: begin
        case (opcode)
          bitmap_pkg::op_find: state_next = st_busy_find;
          bitmap_pkg::op_mark: state_next = st_idle;
          // cut and pre-read are consumed and dropped
          bitmap_pkg::op_cut,
          bitmap_pkg::op_preread: state_next = st_idle;
          default: state_next = st_idle;
        endcase
      end
      st_busy_find: begin
        // no new read until the report is out
        if (find_done) begin
          state_next = st_idle;
        end
      end
      default: state_next = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= st_idle;
      mark_strobe <= 1'b0;
      find_strobe <= 1'b0;
    end else begin
      state       <= state_next;
      mark_strobe <= (state == st_decode) && (opcode == bitmap_pkg::op_mark);
      find_strobe <= (state == st_decode) && (opcode == bitmap_pkg::op_find);
    end
  end

  //////////////////////////////
  // field registers
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (state == st_decode && opcode == bitmap_pkg::op_mark) begin
      sack_valid <= cmd_data[bitmap_pkg::MARK_SACK_VALID_BIT];
      aack_valid <= cmd_data[bitmap_pkg::MARK_AACK_VALID_BIT];
      aack_shift <= cmd_data[bitmap_pkg::AACK_SHIFT_LSB +: bitmap_pkg::SHIFT_BITS];
      sack_shift <= cmd_data[bitmap_pkg::SHIFT_BITS-1:0];
    end
    if (state == st_decode && opcode == bitmap_pkg::op_find) begin
      find_offset <= cmd_data[bitmap_pkg::SHIFT_BITS-1:0];
    end
  end

endmodule

`default_nettype wire

/* bitmap_pkg.sv */
`default_nettype none

package bitmap_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////
  localparam int WINDOW_BITS   = 128;
  localparam int BANK_BITS     = 32;
  localparam int N_BANKS       = WINDOW_BITS / BANK_BITS;
  localparam int SHIFT_BITS    = 14;
  localparam int WIN_CNT_BITS  = $clog2(WINDOW_BITS) + 1;
  localparam int BANK_POS_BITS = $clog2(BANK_BITS);
  localparam int BANK_IDX_BITS = $clog2(N_BANKS);

  typedef logic [31:0]              cmd_word_t;
  typedef logic [WINDOW_BITS-1:0]   window_t;
  typedef logic [SHIFT_BITS-1:0]    shift_t;
  typedef logic [15:0]              report_t;
  // count of 0..WINDOW_BITS ones
  typedef logic [WIN_CNT_BITS-1:0]  win_cnt_t;
  typedef logic [BANK_POS_BITS-1:0] bank_pos_t;
  typedef logic [BANK_IDX_BITS-1:0] bank_idx_t;

  //////////////////////////////
  // command and report fields
  //////////////////////////////
  // opcode in bits 31..30
  typedef enum logic [1:0] {
    op_cut     = 2'b00,
    op_mark    = 2'b01,
    op_find    = 2'b10,
    op_preread = 2'b11
  } opcode_t;

  localparam int MARK_AACK_VALID_BIT = 29;
  localparam int MARK_SACK_VALID_BIT = 28;
  localparam int AACK_SHIFT_LSB      = 14;

  localparam logic [1:0] REPORT_TAG_HOLE = 2'b10;

endpackage

`default_nettype wire
